// ==== common/coreBusPkg.sv ====
package coreBusPkg;

  // one issued micro-op, immediate already sign-extended
  typedef struct packed {
    rvIsaPkg::opE                        op;
    logic [rvIsaPkg::xlen-1:0]           pc;
    logic [rvIsaPkg::regAddrW-1:0]       rd;
    logic [rvIsaPkg::regAddrW-1:0]       rs1;
    logic [rvIsaPkg::regAddrW-1:0]       rs2;
    logic [rvIsaPkg::xlen-1:0]           imm;
    logic [rvIsaPkg::csrAddrW-1:0]       csrAddr;
  } uopT;

  typedef struct packed {
    logic                                en;
    logic [rvIsaPkg::csrAddrW-1:0]       addr;
    logic [rvIsaPkg::xlen-1:0]           data;
  } csrWriteT;

  typedef struct packed {
    logic                                take;
    logic [rvIsaPkg::xlen-1:0]           cause;
    logic [rvIsaPkg::xlen-1:0]           epc;
  } trapT;

  // retired op as seen by the outside world
  typedef struct packed {
    logic [rvIsaPkg::xlen-1:0]           pc;
    logic [rvIsaPkg::xlen-1:0]           nextPc;
    logic                                rdWrite;
    logic [rvIsaPkg::regAddrW-1:0]       rd;
    logic [rvIsaPkg::xlen-1:0]           rdData;
    logic                                trapTaken;
  } commitT;

  // debug APB address map
  localparam int apbAddrW = 13;
  localparam int dbgCsrSel = 12;
  // gpr index field when csr space is not selected
  localparam int dbgGprLsb = 3;
  localparam int dbgGprMsb = 7;

endpackage

// ==== common/rvIsaPkg.sv ====
package rvIsaPkg;

  // datapath widths
  localparam int xlen = 64;
  localparam int regAddrW = 5;
  localparam int csrAddrW = 12;
  localparam int gprCount = 32;

  // pre-decoded micro-op kinds
  typedef enum logic [2:0] {
    opAdd,
    opAddi,
    opCsrrw,
    opCsrrs,
    opCsrrc,
    opEcall,
    opMret
  } opE;

  // machine CSRs implemented by the core
  typedef enum logic [csrAddrW-1:0] {
    csrMstatus = 12'h300,
    csrMtvec   = 12'h305,
    csrMepc    = 12'h341,
    csrMcause  = 12'h342
  } csrAddrE;

  // mcause exception codes
  localparam logic [xlen-1:0] causeIllegalInstr = 64'd2;
  localparam logic [xlen-1:0] causeEcallM = 64'd11;

  // mstatus fields
  localparam int mstatusMie = 3;
  localparam int mstatusMpie = 7;

endpackage

// ==== csr/csrFile.sv ====
`timescale 1ns/1ps

module csrFile (
  input  logic                          clk,
  input  logic                          rstN,
  input  coreBusPkg::csrWriteT          csrWrite,
  input  coreBusPkg::trapT              trap,
  input  logic                          mret,
  input  logic [rvIsaPkg::csrAddrW-1:0] rdAddr,
  output logic [rvIsaPkg::xlen-1:0]     rdData,
  output logic                          rdValid,
  input  logic [rvIsaPkg::csrAddrW-1:0] dbgAddr,
  output logic [rvIsaPkg::xlen-1:0]     dbgData,
  output logic                          dbgValid,
  output logic [rvIsaPkg::xlen-1:0]     mtvec,
  output logic [rvIsaPkg::xlen-1:0]     mepc
);

  logic [rvIsaPkg::xlen-1:0] mstatusQ;
  logic [rvIsaPkg::xlen-1:0] mtvecQ;
  logic [rvIsaPkg::xlen-1:0] mepcQ;
  logic [rvIsaPkg::xlen-1:0] mcauseQ;

  function automatic logic isImpl(input logic [rvIsaPkg::csrAddrW-1:0] addr);
    case (addr)
      rvIsaPkg::csrMstatus,
      rvIsaPkg::csrMtvec,
      rvIsaPkg::csrMepc,
      rvIsaPkg::csrMcause: return 1'b1;
      default:             return 1'b0;
    endcase
  endfunction

  function automatic logic [rvIsaPkg::xlen-1:0] readMux(
    input logic [rvIsaPkg::csrAddrW-1:0] addr
  );
    case (addr)
      rvIsaPkg::csrMstatus: return mstatusQ;
      rvIsaPkg::csrMtvec:   return mtvecQ;
      rvIsaPkg::csrMepc:    return mepcQ;
      rvIsaPkg::csrMcause:  return mcauseQ;
      default:              return '0;
    endcase
  endfunction

  // software write wins over trap entry, trap entry over mret
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mstatusQ <= '0;
    end else if (csrWrite.en && (csrWrite.addr == rvIsaPkg::csrMstatus)) begin
      mstatusQ <= csrWrite.data;
    end else if (trap.take) begin
      mstatusQ[rvIsaPkg::mstatusMpie] <= mstatusQ[rvIsaPkg::mstatusMie];
      mstatusQ[rvIsaPkg::mstatusMie] <= 1'b0;
    end else if (mret) begin
      mstatusQ[rvIsaPkg::mstatusMie] <= mstatusQ[rvIsaPkg::mstatusMpie];
      mstatusQ[rvIsaPkg::mstatusMpie] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mtvecQ <= '0;
    end else if (csrWrite.en && (csrWrite.addr == rvIsaPkg::csrMtvec)) begin
      mtvecQ <= csrWrite.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mepcQ <= '0;
    end else if (csrWrite.en && (csrWrite.addr == rvIsaPkg::csrMepc)) begin
      mepcQ <= csrWrite.data;
    end else if (trap.take) begin
      mepcQ <= trap.epc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mcauseQ <= '0;
    end else if (csrWrite.en && (csrWrite.addr == rvIsaPkg::csrMcause)) begin
      mcauseQ <= csrWrite.data;
    end else if (trap.take) begin
      mcauseQ <= trap.cause;
    end
  end

  assign rdData = readMux(rdAddr);
  assign rdValid = isImpl(rdAddr);
  assign dbgData = readMux(dbgAddr);
  assign dbgValid = isImpl(dbgAddr);

  // redirect targets
  assign mtvec = mtvecQ;
  assign mepc = mepcQ;

endmodule

// ==== logic/debugApb.sv ====
`timescale 1ns/1ps

module debugApb (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [coreBusPkg::apbAddrW-1:0] paddr,
  input  logic [rvIsaPkg::xlen-1:0]       pwdata,
  output logic [rvIsaPkg::xlen-1:0]       prdata,
  output logic                            pready,
  output logic                            pslverr,
  output logic [rvIsaPkg::regAddrW-1:0]   gprAddr,
  input  logic [rvIsaPkg::xlen-1:0]       gprData,
  output logic [rvIsaPkg::csrAddrW-1:0]   csrAddr,
  input  logic [rvIsaPkg::xlen-1:0]       csrData,
  input  logic                            csrValid
);

  typedef enum logic {
    phIdle,
    phAccess
  } phaseE;

  phaseE phase;
  logic  isCsr;

  assign isCsr = paddr[coreBusPkg::dbgCsrSel];
  assign gprAddr = paddr[coreBusPkg::dbgGprMsb:coreBusPkg::dbgGprLsb];
  assign csrAddr = paddr[rvIsaPkg::csrAddrW-1:0];

  // response is captured in setup and shown in access
  always_ff @(posedge clk) begin
    if (!rstN) begin
      phase <= phIdle;
      pslverr <= 1'b0;
    end else begin
      case (phase)
        phIdle: begin
          if (psel && !penable) begin
            phase <= phAccess;
            pslverr <= pwrite || (isCsr && !csrValid);
          end
        end
        default: begin
          phase <= phIdle;
          pslverr <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((phase == phIdle) && psel && !penable) begin
      // writes read back as zero
      prdata <= pwrite ? '0 : (isCsr ? csrData : gprData);
    end
  end

  assign pready = (phase == phAccess);

endmodule

// ==== logic/execUnit.sv ====
`timescale 1ns/1ps

module execUnit (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          uopValid,
  input  coreBusPkg::uopT               uop,
  output logic [rvIsaPkg::regAddrW-1:0] r1Addr,
  input  logic [rvIsaPkg::xlen-1:0]     r1Data,
  output logic [rvIsaPkg::regAddrW-1:0] r2Addr,
  input  logic [rvIsaPkg::xlen-1:0]     r2Data,
  output logic                          wen,
  output logic [rvIsaPkg::regAddrW-1:0] waddr,
  output logic [rvIsaPkg::xlen-1:0]     wdata,
  output logic [rvIsaPkg::csrAddrW-1:0] csrRdAddr,
  input  logic [rvIsaPkg::xlen-1:0]     csrRdData,
  input  logic                          csrRdValid,
  input  logic [rvIsaPkg::xlen-1:0]     mtvec,
  input  logic [rvIsaPkg::xlen-1:0]     mepc,
  output coreBusPkg::csrWriteT          csrWrite,
  output coreBusPkg::trapT              trap,
  output logic                          mretPulse,
  output logic                          commitValid,
  output coreBusPkg::commitT            commit
);

  logic                      rdWrite;
  logic [rvIsaPkg::xlen-1:0] rdVal;
  logic [rvIsaPkg::xlen-1:0] nextPc;
  coreBusPkg::csrWriteT      csrWr;
  coreBusPkg::trapT          trapReq;
  logic                      mretReq;
  coreBusPkg::commitT        commitNext;

  assign r1Addr = uop.rs1;
  assign r2Addr = uop.rs2;
  assign csrRdAddr = uop.csrAddr;

  always_comb begin
    rdWrite = 1'b0;
    rdVal = '0;
    nextPc = uop.pc + 64'd4;
    csrWr = '0;
    trapReq = '0;
    mretReq = 1'b0;
    case (uop.op)
      rvIsaPkg::opAdd: begin
        rdWrite = 1'b1;
        rdVal = r1Data + r2Data;
      end
      rvIsaPkg::opAddi: begin
        rdWrite = 1'b1;
        rdVal = r1Data + uop.imm;
      end
      rvIsaPkg::opCsrrw, rvIsaPkg::opCsrrs, rvIsaPkg::opCsrrc: begin
        if (!csrRdValid) begin
          trapReq.take = 1'b1;
          trapReq.cause = rvIsaPkg::causeIllegalInstr;
          nextPc = mtvec;
        end else begin
          rdWrite = 1'b1;
          rdVal = csrRdData;
          csrWr.addr = uop.csrAddr;
          // set/clear with rs1 = x0 must not write
          csrWr.en = (uop.op == rvIsaPkg::opCsrrw) || (uop.rs1 != '0);
          if (uop.op == rvIsaPkg::opCsrrw) begin
            csrWr.data = r1Data;
          end else if (uop.op == rvIsaPkg::opCsrrs) begin
            csrWr.data = csrRdData | r1Data;
          end else begin
            csrWr.data = csrRdData & ~r1Data;
          end
        end
      end
      rvIsaPkg::opEcall: begin
        trapReq.take = 1'b1;
        trapReq.cause = rvIsaPkg::causeEcallM;
        nextPc = mtvec;
      end
      rvIsaPkg::opMret: begin
        mretReq = 1'b1;
        nextPc = mepc;
      end
      default: begin
        trapReq.take = 1'b1;
        trapReq.cause = rvIsaPkg::causeIllegalInstr;
        nextPc = mtvec;
      end
    endcase
    trapReq.epc = uop.pc;
  end

  // side effects only for a valid op
  assign wen = uopValid && rdWrite;
  assign waddr = uop.rd;
  assign wdata = rdVal;

  always_comb begin
    csrWrite = csrWr;
    csrWrite.en = uopValid && csrWr.en;
    trap = trapReq;
    trap.take = uopValid && trapReq.take;
  end

  assign mretPulse = uopValid && mretReq;

  always_comb begin
    commitNext.pc = uop.pc;
    commitNext.nextPc = nextPc;
    commitNext.rdWrite = rdWrite;
    commitNext.rd = uop.rd;
    commitNext.rdData = rdVal;
    commitNext.trapTaken = trapReq.take;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      commitValid <= 1'b0;
    end else begin
      commitValid <= uopValid;
    end
  end

  always_ff @(posedge clk) begin
    if (uopValid) begin
      commit <= commitNext;
    end
  end

endmodule

// ==== logic/sysCore.sv ====
`timescale 1ns/1ps

module sysCore (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            uopValid,
  input  coreBusPkg::uopT                 uop,
  output logic                            commitValid,
  output coreBusPkg::commitT              commit,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [coreBusPkg::apbAddrW-1:0] paddr,
  input  logic [rvIsaPkg::xlen-1:0]       pwdata,
  output logic [rvIsaPkg::xlen-1:0]       prdata,
  output logic                            pready,
  output logic                            pslverr
);

  logic [rvIsaPkg::regAddrW-1:0] r1Addr;
  logic [rvIsaPkg::regAddrW-1:0] r2Addr;
  logic [rvIsaPkg::xlen-1:0]     r1Data;
  logic [rvIsaPkg::xlen-1:0]     r2Data;
  logic                          gprWen;
  logic [rvIsaPkg::regAddrW-1:0] gprWaddr;
  logic [rvIsaPkg::xlen-1:0]     gprWdata;
  logic [rvIsaPkg::regAddrW-1:0] dbgGprAddr;
  logic [rvIsaPkg::xlen-1:0]     dbgGprData;
  logic [rvIsaPkg::csrAddrW-1:0] csrRdAddr;
  logic [rvIsaPkg::xlen-1:0]     csrRdData;
  logic                          csrRdValid;
  logic [rvIsaPkg::csrAddrW-1:0] dbgCsrAddr;
  logic [rvIsaPkg::xlen-1:0]     dbgCsrData;
  logic                          dbgCsrValid;
  logic [rvIsaPkg::xlen-1:0]     mtvec;
  logic [rvIsaPkg::xlen-1:0]     mepc;
  coreBusPkg::csrWriteT          csrWrite;
  coreBusPkg::trapT              trap;
  logic                          mretPulse;

  gprFile gprs (
    .clk(clk), .rstN(rstN),
    .r1Addr(r1Addr), .r1Data(r1Data),
    .r2Addr(r2Addr), .r2Data(r2Data),
    .dbgAddr(dbgGprAddr), .dbgData(dbgGprData),
    .wen(gprWen), .waddr(gprWaddr), .wdata(gprWdata)
  );

  csrFile csrs (
    .clk(clk), .rstN(rstN),
    .csrWrite(csrWrite), .trap(trap), .mret(mretPulse),
    .rdAddr(csrRdAddr), .rdData(csrRdData), .rdValid(csrRdValid),
    .dbgAddr(dbgCsrAddr), .dbgData(dbgCsrData), .dbgValid(dbgCsrValid),
    .mtvec(mtvec), .mepc(mepc)
  );

  execUnit exec (
    .clk(clk), .rstN(rstN),
    .uopValid(uopValid), .uop(uop),
    .r1Addr(r1Addr), .r1Data(r1Data), .r2Addr(r2Addr), .r2Data(r2Data),
    .wen(gprWen), .waddr(gprWaddr), .wdata(gprWdata),
    .csrRdAddr(csrRdAddr), .csrRdData(csrRdData), .csrRdValid(csrRdValid),
    .mtvec(mtvec), .mepc(mepc),
    .csrWrite(csrWrite), .trap(trap), .mretPulse(mretPulse),
    .commitValid(commitValid), .commit(commit)
  );

  debugApb dbg (
    .clk(clk), .rstN(rstN),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .gprAddr(dbgGprAddr), .gprData(dbgGprData),
    .csrAddr(dbgCsrAddr), .csrData(dbgCsrData), .csrValid(dbgCsrValid)
  );

endmodule

// ==== regfile/gprFile.sv ====
`timescale 1ns/1ps

module gprFile (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic [rvIsaPkg::regAddrW-1:0] r1Addr,
  output logic [rvIsaPkg::xlen-1:0]     r1Data,
  input  logic [rvIsaPkg::regAddrW-1:0] r2Addr,
  output logic [rvIsaPkg::xlen-1:0]     r2Data,
  input  logic [rvIsaPkg::regAddrW-1:0] dbgAddr,
  output logic [rvIsaPkg::xlen-1:0]     dbgData,
  input  logic                          wen,
  input  logic [rvIsaPkg::regAddrW-1:0] waddr,
  input  logic [rvIsaPkg::xlen-1:0]     wdata
);

  logic [rvIsaPkg::xlen-1:0] regs [rvIsaPkg::gprCount];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < rvIsaPkg::gprCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads as zero on every port
  assign r1Data = (r1Addr == '0) ? '0 : regs[r1Addr];
  assign r2Data = (r2Addr == '0) ? '0 : regs[r2Addr];
  assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the sysCore testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module sysCoreTb -f tb.f -o sysCoreSim

./obj_dir/sysCoreSim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a result line, see sim.log"
  exit 1
fi

echo "simulation finished cleanly"

// ==== tb.f ====
common/rvIsaPkg.sv
common/coreBusPkg.sv
regfile/gprFile.sv
csr/csrFile.sv
logic/execUnit.sv
logic/debugApb.sv
logic/sysCore.sv
verification/sysCoreTb.sv

// ==== verification/sysCoreTb.sv ====
`timescale 1ns/1ps

module sysCoreTb;

  localparam logic [1:0] apbNone = 2'd0;
  localparam logic [1:0] apbGpr = 2'd1;
  localparam logic [1:0] apbCsr = 2'd2;
  localparam logic [1:0] apbWrite = 2'd3;
  localparam logic [11:0] badCsr = 12'h7c0;

  typedef struct packed {
    rvIsaPkg::opE op;
    logic [4:0]   rd;
    logic [4:0]   rs1;
    logic [4:0]   rs2;
    logic [11:0]  csrAddr;
    logic         randImm;
    logic [11:0]  imm;
    logic [1:0]   apbKind;
    logic [11:0]  apbSel;
  } rowT;

  logic clk;
  logic rstN;
  logic uopValid;
  coreBusPkg::uopT uop;
  logic commitValid;
  coreBusPkg::commitT commit;
  logic psel;
  logic penable;
  logic pwrite;
  logic [12:0] paddr;
  logic [63:0] pwdata;
  logic [63:0] prdata;
  logic pready;
  logic pslverr;

  rowT rows[$];
  string names[$];
  logic [63:0] gprM [32];
  logic [63:0] mstatusM;
  logic [63:0] mtvecM;
  logic [63:0] mepcM;
  logic [63:0] mcauseM;
  logic [63:0] pcM;
  logic [63:0] rngState;
  logic [63:0] immVal;
  coreBusPkg::commitT expCommit;
  int numChecks;
  int numErrors;
  int cycles;
  int cycleLimit;
  int apbCount;

  sysCore uut (
    .clk(clk), .rstN(rstN),
    .uopValid(uopValid), .uop(uop),
    .commitValid(commitValid), .commit(commit),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  always #2 clk = ~clk;

  // run limit follows the table length
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycleLimit > 0 && cycles > cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [63:0] xorshift64(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  function automatic logic [63:0] signExt12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic csrExists(input logic [11:0] addr);
    case (addr)
      rvIsaPkg::csrMstatus, rvIsaPkg::csrMtvec,
      rvIsaPkg::csrMepc, rvIsaPkg::csrMcause: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [63:0] csrValue(input logic [11:0] addr);
    case (addr)
      rvIsaPkg::csrMstatus: return mstatusM;
      rvIsaPkg::csrMtvec:   return mtvecM;
      rvIsaPkg::csrMepc:    return mepcM;
      rvIsaPkg::csrMcause:  return mcauseM;
      default:              return 64'd0;
    endcase
  endfunction

  task automatic csrStore(input logic [11:0] addr, input logic [63:0] value);
    case (addr)
      rvIsaPkg::csrMstatus: mstatusM = value;
      rvIsaPkg::csrMtvec:   mtvecM = value;
      rvIsaPkg::csrMepc:    mepcM = value;
      rvIsaPkg::csrMcause:  mcauseM = value;
      default: begin
      end
    endcase
  endtask

  // trap entry on the model state
  task automatic takeTrap(input logic [63:0] pc, input logic [63:0] cause);
    mepcM = pc;
    mcauseM = cause;
    mstatusM[rvIsaPkg::mstatusMpie] = mstatusM[rvIsaPkg::mstatusMie];
    mstatusM[rvIsaPkg::mstatusMie] = 1'b0;
  endtask

  task automatic modelStep(input rowT r, input logic [63:0] imm, input logic [63:0] pc,
                           output coreBusPkg::commitT expected);
    logic [63:0] src1;
    logic [63:0] src2;
    logic [63:0] oldVal;
    logic [63:0] newVal;
    src1 = gprM[r.rs1];
    src2 = gprM[r.rs2];
    expected = '0;
    expected.pc = pc;
    expected.rd = r.rd;
    expected.nextPc = pc + 64'd4;
    case (r.op)
      rvIsaPkg::opAdd: begin
        expected.rdWrite = 1'b1;
        expected.rdData = src1 + src2;
      end
      rvIsaPkg::opAddi: begin
        expected.rdWrite = 1'b1;
        expected.rdData = src1 + imm;
      end
      rvIsaPkg::opCsrrw, rvIsaPkg::opCsrrs, rvIsaPkg::opCsrrc: begin
        if (!csrExists(r.csrAddr)) begin
          expected.trapTaken = 1'b1;
          expected.nextPc = mtvecM;
          takeTrap(pc, 64'd2);
        end else begin
          oldVal = csrValue(r.csrAddr);
          expected.rdWrite = 1'b1;
          expected.rdData = oldVal;
          if (r.op == rvIsaPkg::opCsrrw) begin
            newVal = src1;
          end else if (r.op == rvIsaPkg::opCsrrs) begin
            newVal = oldVal | src1;
          end else begin
            newVal = oldVal & ~src1;
          end
          if (r.op == rvIsaPkg::opCsrrw || r.rs1 != 5'd0) begin
            csrStore(r.csrAddr, newVal);
          end
        end
      end
      rvIsaPkg::opEcall: begin
        expected.trapTaken = 1'b1;
        expected.nextPc = mtvecM;
        takeTrap(pc, 64'd11);
      end
      rvIsaPkg::opMret: begin
        expected.nextPc = mepcM;
        mstatusM[rvIsaPkg::mstatusMie] = mstatusM[rvIsaPkg::mstatusMpie];
        mstatusM[rvIsaPkg::mstatusMpie] = 1'b1;
      end
      default: begin
      end
    endcase
    if (expected.rdWrite && r.rd != 5'd0) begin
      gprM[r.rd] = expected.rdData;
    end
  endtask

  task automatic compareField(input string rowName, input string field,
                              input logic [63:0] expected, input logic [63:0] actual);
    numChecks = numChecks + 1;
    if (actual !== expected) begin
      numErrors = numErrors + 1;
      $display("CHECK FAILED %s %s: expected %h, actual %h",
               rowName, field, expected, actual);
    end
  endtask

  task automatic checkCommit(input string rowName, input coreBusPkg::commitT expected);
    compareField(rowName, "pc", expected.pc, commit.pc);
    compareField(rowName, "nextPc", expected.nextPc, commit.nextPc);
    compareField(rowName, "rdWrite", 64'(expected.rdWrite), 64'(commit.rdWrite));
    compareField(rowName, "trapTaken", 64'(expected.trapTaken), 64'(commit.trapTaken));
    if (expected.rdWrite) begin
      compareField(rowName, "rd", 64'(expected.rd), 64'(commit.rd));
      compareField(rowName, "rdData", expected.rdData, commit.rdData);
    end
  endtask

  // one APB transfer, starting on a falling edge
  task automatic apbTransfer(input string rowName, input logic [1:0] kind,
                             input logic [11:0] sel);
    logic [63:0] expData;
    logic expErr;
    int waitCycles;
    paddr = 13'd0;
    pwrite = 1'b0;
    expData = 64'd0;
    expErr = 1'b0;
    if (kind == apbGpr) begin
      paddr[7:3] = sel[4:0];
      expData = gprM[sel[4:0]];
    end else begin
      paddr = {1'b1, sel};
      expErr = !csrExists(sel);
      expData = csrValue(sel);
    end
    if (kind == apbWrite) begin
      rngState = xorshift64(rngState);
      pwdata = rngState;
      pwrite = 1'b1;
      expErr = 1'b1;
    end
    psel = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    waitCycles = 0;
    while (!pready && waitCycles < 4) begin
      @(negedge clk);
      waitCycles = waitCycles + 1;
    end
    if (!pready) begin
      numErrors = numErrors + 1;
      $display("row %s: APB access phase never saw pready", rowName);
    end else begin
      compareField(rowName, "pslverr", 64'(expErr), 64'(pslverr));
      if (!expErr) begin
        compareField(rowName, "prdata", expData, prdata);
      end
    end
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic addRow(input string name, input rvIsaPkg::opE op, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] csr,
                        input logic randImm, input logic [11:0] imm,
                        input logic [1:0] apbKind, input logic [11:0] apbSel);
    rowT r;
    r.op = op;
    r.rd = rd;
    r.rs1 = rs1;
    r.rs2 = rs2;
    r.csrAddr = csr;
    r.randImm = randImm;
    r.imm = imm;
    r.apbKind = apbKind;
    r.apbSel = apbSel;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic buildTable();
    // name, op, rd, rs1, rs2, csr, random imm, imm, apb access, apb target
    addRow("addi x1", rvIsaPkg::opAddi, 5'd1, 5'd0, 5'd0, 12'h0, 1'b1, 12'h0, apbGpr, 12'd1);
    addRow("addi x2 dep", rvIsaPkg::opAddi, 5'd2, 5'd1, 5'd0, 12'h0, 1'b1, 12'h0,
           apbNone, 12'd0);
    addRow("add x3 dep", rvIsaPkg::opAdd, 5'd3, 5'd1, 5'd2, 12'h0, 1'b1, 12'h0,
           apbGpr, 12'd3);
    addRow("add to x0", rvIsaPkg::opAdd, 5'd0, 5'd3, 5'd3, 12'h0, 1'b1, 12'h0, apbGpr, 12'd0);
    addRow("add x4", rvIsaPkg::opAdd, 5'd4, 5'd3, 5'd0, 12'h0, 1'b1, 12'h0, apbGpr, 12'd4);
    addRow("csrrw mtvec", rvIsaPkg::opCsrrw, 5'd5, 5'd3, 5'd0, rvIsaPkg::csrMtvec, 1'b1,
           12'h0, apbCsr, rvIsaPkg::csrMtvec);
    addRow("li mie bit", rvIsaPkg::opAddi, 5'd6, 5'd0, 5'd0, 12'h0, 1'b0, 12'h008,
           apbNone, 12'd0);
    addRow("csrrs mstatus", rvIsaPkg::opCsrrs, 5'd7, 5'd6, 5'd0, rvIsaPkg::csrMstatus, 1'b1,
           12'h0, apbCsr, rvIsaPkg::csrMstatus);
    addRow("csrrs x0 mstatus", rvIsaPkg::opCsrrs, 5'd8, 5'd0, 5'd0, rvIsaPkg::csrMstatus,
           1'b1, 12'h0, apbCsr, rvIsaPkg::csrMstatus);
    addRow("csrrw mepc", rvIsaPkg::opCsrrw, 5'd9, 5'd4, 5'd0, rvIsaPkg::csrMepc, 1'b1,
           12'h0, apbNone, 12'd0);
    addRow("csrrc mepc", rvIsaPkg::opCsrrc, 5'd10, 5'd1, 5'd0, rvIsaPkg::csrMepc, 1'b1,
           12'h0, apbCsr, rvIsaPkg::csrMepc);
    addRow("csrrw mcause", rvIsaPkg::opCsrrw, 5'd11, 5'd2, 5'd0, rvIsaPkg::csrMcause, 1'b1,
           12'h0, apbNone, 12'd0);
    addRow("csrrc x0 mcause", rvIsaPkg::opCsrrc, 5'd12, 5'd0, 5'd0, rvIsaPkg::csrMcause,
           1'b1, 12'h0, apbCsr, rvIsaPkg::csrMcause);
    addRow("ecall", rvIsaPkg::opEcall, 5'd0, 5'd0, 5'd0, 12'h0, 1'b1, 12'h0,
           apbCsr, rvIsaPkg::csrMepc);
    addRow("read mcause", rvIsaPkg::opCsrrs, 5'd13, 5'd0, 5'd0, rvIsaPkg::csrMcause, 1'b1,
           12'h0, apbCsr, rvIsaPkg::csrMstatus);
    addRow("mret", rvIsaPkg::opMret, 5'd0, 5'd0, 5'd0, 12'h0, 1'b1, 12'h0,
           apbCsr, rvIsaPkg::csrMstatus);
    addRow("bad csr", rvIsaPkg::opCsrrw, 5'd14, 5'd1, 5'd0, badCsr, 1'b1, 12'h0,
           apbGpr, 12'd14);
    addRow("read cause 2", rvIsaPkg::opCsrrs, 5'd15, 5'd0, 5'd0, rvIsaPkg::csrMcause, 1'b1,
           12'h0, apbCsr, badCsr);
    addRow("read mepc", rvIsaPkg::opCsrrs, 5'd16, 5'd0, 5'd0, rvIsaPkg::csrMepc, 1'b1,
           12'h0, apbWrite, rvIsaPkg::csrMtvec);
    addRow("ecall again", rvIsaPkg::opEcall, 5'd0, 5'd0, 5'd0, 12'h0, 1'b1, 12'h0,
           apbCsr, rvIsaPkg::csrMstatus);
    addRow("add after trap", rvIsaPkg::opAdd, 5'd17, 5'd15, 5'd16, 12'h0, 1'b1, 12'h0,
           apbGpr, 12'd17);
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    uopValid = 1'b0;
    uop = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 13'd0;
    pwdata = 64'd0;
    numChecks = 0;
    numErrors = 0;
    cycles = 0;
    cycleLimit = 0;
    apbCount = 0;
    rngState = 64'd68280;
    for (int r = 0; r < 32; r++) begin
      gprM[r] = 64'd0;
    end
    mstatusM = 64'd0;
    mtvecM = 64'd0;
    mepcM = 64'd0;
    mcauseM = 64'd0;
    pcM = 64'h1000;

    buildTable();
    foreach (rows[k]) begin
      if (rows[k].apbKind != apbNone) begin
        apbCount = apbCount + 1;
      end
    end
    cycleLimit = 4 * rows.size() + 3 * apbCount + 50;

    repeat (5) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);
    compareField("reset", "commitValid", 64'd0, 64'(commitValid));
    compareField("reset", "pready", 64'd0, 64'(pready));
    compareField("reset", "pslverr", 64'd0, 64'(pslverr));

    // ops issue back to back unless an APB read sits between them
    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].randImm) begin
        rngState = xorshift64(rngState);
        immVal = signExt12(rngState[11:0]);
      end else begin
        immVal = signExt12(rows[i].imm);
      end
      uop = '0;
      uop.op = rows[i].op;
      uop.pc = pcM;
      uop.rd = rows[i].rd;
      uop.rs1 = rows[i].rs1;
      uop.rs2 = rows[i].rs2;
      uop.imm = immVal;
      uop.csrAddr = rows[i].csrAddr;
      uopValid = 1'b1;
      modelStep(rows[i], immVal, pcM, expCommit);
      pcM = expCommit.nextPc;
      @(negedge clk);
      uopValid = 1'b0;
      if (!commitValid) begin
        numErrors = numErrors + 1;
        $display("row %s: no commit came out one cycle after the op was issued", names[i]);
      end else begin
        checkCommit(names[i], expCommit);
      end
      if (rows[i].apbKind != apbNone) begin
        apbTransfer(names[i], rows[i].apbKind, rows[i].apbSel);
      end
    end

    $display("checks: %0d, errors: %0d", numChecks, numErrors);
    if (numErrors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
